/* sim/golden_program.txt */
# I <word>           program word, in address order from 0
# W <reg> <value>    register write in commit order; S <addr> <data> store in order
I E3A01011  # 00 mov r1, #0x11
I E3A024FF  # 04 mov r2, #0xff000000
I E2813022  # 08 add r3, r1, #0x22
I E0834003  # 0c add r4, r3, r3
I E2445001  # 10 sub r5, r4, #1
I E20560F0  # 14 and r6, r5, #0xf0
I E1867002  # 18 orr r7, r6, r2
I E3828E3F  # 1c orr r8, r2, #0x3f0
I E581700F  # 20 str r7, [r1, #0xf]
I E5139013  # 24 ldr r9, [r3, #-0x13]
I E289A001  # 28 add r10, r9, #1
I 13A0B005  # 2c movne r11, #5
I 00000000  # 30 zero word
I 1581700F  # 34 strne r7, [r1, #0xf]
I E28FC000  # 38 add r12, r15, #0
I E08CB00A  # 3c add r11, r12, r10
W 1 00000011
W 2 FF000000
W 3 00000033
W 4 00000066
W 5 00000065
W 6 00000060
W 7 FF000060
W 8 FF0003F0
W 9 FF000060
W A FF000061
W C 00000040
W B FF0000A1
S 00000020 FF000060

/* flist.f */
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/hazardUnit.sv
source/executeStage.sv
source/pipelineCore.sv
sim/coreTb.sv

/* Makefile */
# Verilator simulation of the pipelined core
VERILATOR ?= verilator
TOP       ?= coreTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

PASS_TEXT := All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/coreTb.sv */
`include "core_cfg.svh"

module coreTb;

  localparam int    clkPeriod   = 20;
  localparam int    resetCycles = 16;
  localparam int    drainCycles = 8;   // Quiet cycles after the last expected event
  localparam int    memWords    = 64;  // Both memories hold words indexed by addr[7:2]
  localparam string goldenPath  = "sim/golden_program.txt";

  logic                   clk;
  logic                   rstN;
  logic [`DATA_WIDTH-1:0] instrAddr;
  logic [`DATA_WIDTH-1:0] instr;
  logic [`DATA_WIDTH-1:0] readData;
  pipePkg::dataBusT       dataBus;
  pipePkg::wbPortT        wbPort;

  logic [`DATA_WIDTH-1:0] imem [0:memWords-1];
  logic [`DATA_WIDTH-1:0] dmem [0:memWords-1];
  int                     progLen;
  logic                   loaded;
  logic [`DATA_WIDTH-1:0] prevAddr;  // Fetch address seen at the last check

  // Expected events consumed front first
  logic [3:0]             expRegQ  [$];
  logic [`DATA_WIDTH-1:0] expValQ  [$];
  logic [`DATA_WIDTH-1:0] expAddrQ [$];
  logic [`DATA_WIDTH-1:0] expDataQ [$];

  int nWrites;
  int nStores;
  int writesSeen;
  int storesSeen;
  int watchdogTime;

  pipelineCore dut0 (
    .clk       (clk),
    .rstN      (rstN),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dataBus   (dataBus),
    .readData  (readData),
    .wbPort    (wbPort)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic abortRun();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  // Tag letter first, then one or two hex fields
  task automatic loadGolden();
    int         fd;
    int         cnt;
    string      line;
    logic [7:0] tag;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen(goldenPath, "r");
    if (fd == 0) begin
      $display("Cannot open the golden file %s", goldenPath);
      abortRun();
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
        cnt = $sscanf(line, "%c %h %h", tag, a, b);
        if (tag == "I" && cnt >= 2 && progLen < memWords) begin
          imem[progLen] = a;
          progLen++;
        end else if (tag == "W" && cnt == 3) begin
          expRegQ.push_back(a[3:0]);
          expValQ.push_back(b);
        end else if (tag == "S" && cnt == 3) begin
          expAddrQ.push_back(a);
          expDataQ.push_back(b);
        end else begin
          $display("Golden file line not understood: %s", line);
          abortRun();
        end
      end
      $fclose(fd);
    end
  endtask

  // Data memory takes stores on the rising edge
  always @(posedge clk) begin
    if (dataBus.write) dmem[dataBus.addr[7:2]] <= dataBus.wdata;
  end

  // Outputs are stable here, so check first and then drive
  always @(negedge clk) begin
    if (rstN) begin
      // PC steps one word per cycle or holds during a load-use stall
      if (instrAddr !== prevAddr) begin
        checkValue("instrAddr", instrAddr, prevAddr + `DATA_WIDTH'(`PC_STEP));
      end
      prevAddr = instrAddr;
      if (wbPort.valid) begin
        if (expRegQ.size() == 0) begin
          $display("Register write to r%0d at %0t after the last expected write",
                   wbPort.regAddr, $time);
          abortRun();
        end else begin
          checkValue("wbPort.regAddr", 32'(wbPort.regAddr), 32'(expRegQ[0]));
          checkValue("wbPort.data", wbPort.data, expValQ[0]);
          void'(expRegQ.pop_front());
          void'(expValQ.pop_front());
          writesSeen++;
        end
      end
      if (dataBus.write) begin
        if (expAddrQ.size() == 0) begin
          $display("Store to %h at %0t after the last expected store", dataBus.addr, $time);
          abortRun();
        end else begin
          checkValue("dataBus.addr", dataBus.addr, expAddrQ[0]);
          checkValue("dataBus.wdata", dataBus.wdata, expDataQ[0]);
          void'(expAddrQ.pop_front());
          void'(expDataQ.pop_front());
          storesSeen++;
        end
      end
    end
    // Zero past the program end is a no-op
    if ((instrAddr >> 2) < progLen) instr = imem[instrAddr[7:2]];
    else instr = '0;
    readData = dmem[dataBus.addr[7:2]];
  end

  // Watchdog sized from the golden file
  initial begin
    wait (loaded);
    #(watchdogTime);
    $display("Timeout: only %0d of %0d writes and %0d of %0d stores seen",
             writesSeen, nWrites, storesSeen, nStores);
    abortRun();
  end

  initial begin
    rstN       = 1'b0;
    instr      = '0;
    readData   = '0;
    loaded     = 1'b0;
    progLen    = 0;
    writesSeen = 0;
    storesSeen = 0;
    prevAddr   = `DATA_WIDTH'(`RESET_PC);
    for (int i = 0; i < memWords; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    loadGolden();
    nWrites      = expRegQ.size();
    nStores      = expAddrQ.size();
    watchdogTime = (progLen + nWrites + 20) * 4 * clkPeriod;
    loaded       = 1'b1;

    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;

    wait (writesSeen == nWrites && storesSeen == nStores);
    repeat (drainCycles) @(posedge clk);  // Stray writes or stores show up here

    $display("All checks passed");
    $finish;
  end

endmodule

/* source/pipelineCore.sv */
`include "core_cfg.svh"

module pipelineCore (
  input  logic                    clk,
  input  logic                    rstN,
  output logic [`DATA_WIDTH-1:0]  instrAddr,
  input  logic [`DATA_WIDTH-1:0]  instr,
  output pipePkg::dataBusT        dataBus,
  input  logic [`DATA_WIDTH-1:0]  readData,
  output pipePkg::wbPortT         wbPort
);

  // Fetch to decode register contents
  typedef struct packed {
    isaPkg::instrWordT      instr;
    logic [`DATA_WIDTH-1:0] pcPlus4;
  } fetchDecT;

  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] pcPlus4F;
  logic [`DATA_WIDTH-1:0] pcPlus8D;
  logic                   stall;

  fetchDecT fetchDec;

  pipePkg::ctrlT          ctrlD;
  isaPkg::regAddrT        rnD;
  isaPkg::regAddrT        rmD;
  isaPkg::regAddrT        rdD;
  logic [`DATA_WIDTH-1:0] extImmD;
  logic [`DATA_WIDTH-1:0] rd1D;
  logic [`DATA_WIDTH-1:0] rd2D;

  pipePkg::decExT  decExD;
  pipePkg::decExT  decEx;
  pipePkg::exMemT  exMemD;
  pipePkg::exMemT  exMem;
  pipePkg::memWbT  memWbD;
  pipePkg::memWbT  memWb;

  pipePkg::fwdSelT        fwdA;
  pipePkg::fwdSelT        fwdB;
  logic [`DATA_WIDTH-1:0] aluOutE;
  logic [`DATA_WIDTH-1:0] writeDataE;
  logic [`DATA_WIDTH-1:0] resultW;

  // Fetch
  assign pcPlus4F  = pc + `DATA_WIDTH'(`PC_STEP);
  assign instrAddr = pc;

  always_ff @(posedge clk) begin
    if (!rstN) pc <= `DATA_WIDTH'(`RESET_PC);
    else if (!stall) pc <= pcPlus4F;  // No branches so always sequential
  end

  // All-zero word decodes as a no-op
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fetchDec <= '0;
    end else if (!stall) begin
      fetchDec.instr   <= instr;
      fetchDec.pcPlus4 <= pcPlus4F;
    end
  end

  // Decode
  assign pcPlus8D = fetchDec.pcPlus4 + `DATA_WIDTH'(`PC_STEP);

  instrDecoder dec0 (
    .instr  (fetchDec.instr),
    .ctrl   (ctrlD),
    .rn     (rnD),
    .rm     (rmD),
    .rd     (rdD),
    .extImm (extImmD)
  );

  regFile rf0 (
    .clk     (clk),
    .ra1     (rnD),
    .ra2     (rmD),
    .wa      (memWb.rd),
    .we      (memWb.regWrite),
    .wd      (resultW),
    .pcPlus8 (pcPlus8D),  // r15 seen by this instruction
    .rd1     (rd1D),
    .rd2     (rd2D)
  );

  hazardUnit hz0 (
    .rnD   (rnD),
    .rmD   (rmD),
    .rnE   (decEx.rn),
    .rmE   (decEx.rm),
    .loadE (decEx.ctrl.memToReg),
    .rdE   (decEx.rd),
    .exMem (exMem),
    .memWb (memWb),
    .fwdA  (fwdA),
    .fwdB  (fwdB),
    .stall (stall)
  );

  always_comb begin
    decExD.ctrl   = ctrlD;
    decExD.rn     = rnD;
    decExD.rm     = rmD;
    decExD.rd     = rdD;
    decExD.rd1    = rd1D;
    decExD.rd2    = rd2D;
    decExD.extImm = extImmD;
  end

  // Bubble on reset and on a load-use stall
  always_ff @(posedge clk) begin
    if (!rstN || stall) decEx.ctrl <= '0;
    else decEx <= decExD;
  end

  // Execute
  executeStage ex0 (
    .decEx     (decEx),
    .fwdA      (fwdA),
    .fwdB      (fwdB),
    .memFwd    (exMem.aluOut),
    .wbFwd     (resultW),
    .aluOut    (aluOutE),
    .writeData (writeDataE)
  );

  always_comb begin
    exMemD.ctrl      = decEx.ctrl;
    exMemD.rd        = decEx.rd;
    exMemD.aluOut    = aluOutE;
    exMemD.writeData = writeDataE;
  end

  always_ff @(posedge clk) begin
    if (!rstN) exMem.ctrl <= '0;
    else exMem <= exMemD;
  end

  // Memory stage answered in the same cycle
  assign dataBus.addr  = exMem.aluOut;
  assign dataBus.wdata = exMem.writeData;
  assign dataBus.write = exMem.ctrl.memWrite;

  always_comb begin
    memWbD.regWrite = exMem.ctrl.regWrite;
    memWbD.memToReg = exMem.ctrl.memToReg;
    memWbD.rd       = exMem.rd;
    memWbD.aluOut   = exMem.aluOut;
    memWbD.readData = readData;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWb.regWrite <= 1'b0;
      memWb.memToReg <= 1'b0;
    end else begin
      memWb <= memWbD;
    end
  end

  // Writeback
  assign resultW = memWb.memToReg ? memWb.readData : memWb.aluOut;

  assign wbPort.valid   = memWb.regWrite;
  assign wbPort.regAddr = memWb.rd;
  assign wbPort.data    = resultW;

  // A load in M holds only its address so no live user may bypass from M
  loadNoMemBypass: assert property (@(posedge clk) disable iff (!rstN)
    (exMem.ctrl.memToReg && decEx.ctrl != '0) |->
      (fwdA != pipePkg::fwdMem && fwdB != pipePkg::fwdMem));

endmodule

/* source/executeStage.sv */
`include "core_cfg.svh"

module executeStage (
  input  pipePkg::decExT          decEx,
  input  pipePkg::fwdSelT         fwdA,
  input  pipePkg::fwdSelT         fwdB,
  input  logic [`DATA_WIDTH-1:0]  memFwd,
  input  logic [`DATA_WIDTH-1:0]  wbFwd,
  output logic [`DATA_WIDTH-1:0]  aluOut,
  output logic [`DATA_WIDTH-1:0]  writeData
);

  logic [`DATA_WIDTH-1:0] srcA;
  logic [`DATA_WIDTH-1:0] srcB;

  // Three-way bypass mux shared by both operands
  function automatic logic [`DATA_WIDTH-1:0] pickOperand(
    input pipePkg::fwdSelT        sel,
    input logic [`DATA_WIDTH-1:0] regVal,
    input logic [`DATA_WIDTH-1:0] memVal,
    input logic [`DATA_WIDTH-1:0] wbVal
  );
    case (sel)
      pipePkg::fwdMem: return memVal;
      pipePkg::fwdWb:  return wbVal;
      default:         return regVal;
    endcase
  endfunction

  assign srcA      = pickOperand(fwdA, decEx.rd1, memFwd, wbFwd);
  assign writeData = pickOperand(fwdB, decEx.rd2, memFwd, wbFwd);  // Also the store data

  // Immediate for imm forms and all memory addresses
  assign srcB = decEx.ctrl.aluSrcImm ? decEx.extImm : writeData;

  always_comb begin
    case (decEx.ctrl.aluOp)
      isaPkg::ANDop: aluOut = srcA & srcB;
      isaPkg::SUBop: aluOut = srcA - srcB;  // Also down-offset address
      isaPkg::ADDop: aluOut = srcA + srcB;
      isaPkg::ORRop: aluOut = srcA | srcB;
      isaPkg::MOVop: aluOut = srcB;  // Rn ignored
      default:       aluOut = '0;
    endcase
  end

endmodule

/* source/hazardUnit.sv */
module hazardUnit (
  input  isaPkg::regAddrT  rnD,
  input  isaPkg::regAddrT  rmD,
  input  isaPkg::regAddrT  rnE,
  input  isaPkg::regAddrT  rmE,
  input  logic             loadE,
  input  isaPkg::regAddrT  rdE,
  input  pipePkg::exMemT   exMem,
  input  pipePkg::memWbT   memWb,
  output pipePkg::fwdSelT  fwdA,
  output pipePkg::fwdSelT  fwdB,
  output logic             stall
);

  logic matchAM;  // Source A against memory stage
  logic matchAW;  // Source A against writeback stage
  logic matchBM;
  logic matchBW;
  logic matchDE;  // Decode source against load in execute

  // Memory stage holds the younger value and wins
  function automatic pipePkg::fwdSelT pickFwd(input logic matchM, input logic matchW);
    if (matchM) return pipePkg::fwdMem;
    else if (matchW) return pipePkg::fwdWb;
    else return pipePkg::fwdNone;
  endfunction

  assign matchAM = exMem.ctrl.regWrite && (exMem.rd == rnE);
  assign matchAW = memWb.regWrite && (memWb.rd == rnE);
  assign matchBM = exMem.ctrl.regWrite && (exMem.rd == rmE);
  assign matchBW = memWb.regWrite && (memWb.rd == rmE);

  assign fwdA = pickFwd(matchAM, matchAW);
  assign fwdB = pickFwd(matchBM, matchBW);

  // Load data exists only after the memory stage
  // so a direct user waits one cycle and then takes it from writeback
  assign matchDE = (rdE == rnD) || (rdE == rmD);
  assign stall   = loadE && matchDE;

endmodule

/* source/regFile.sv */
`include "core_cfg.svh"

module regFile (
  input  logic                    clk,
  input  isaPkg::regAddrT         ra1,
  input  isaPkg::regAddrT         ra2,
  input  isaPkg::regAddrT         wa,
  input  logic                    we,
  input  logic [`DATA_WIDTH-1:0]  wd,
  input  logic [`DATA_WIDTH-1:0]  pcPlus8,
  output logic [`DATA_WIDTH-1:0]  rd1,
  output logic [`DATA_WIDTH-1:0]  rd2
);

  // r0..r14 only, r15 is the PC
  logic [`DATA_WIDTH-1:0] regs [0:`REG_COUNT-2];

  // Port value with r15 and same-cycle write handled
  function automatic logic [`DATA_WIDTH-1:0] readPort(input isaPkg::regAddrT ra);
    if (ra == isaPkg::pcReg) return pcPlus8;
    else if (we && ra == wa) return wd;  // Write-through
    else return regs[ra];
  endfunction

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

  always_ff @(posedge clk) begin
    if (we && wa != isaPkg::pcReg) begin
      regs[wa] <= wd;
    end
  end

  // Decoder turns every rd=r15 write into a no-op
  noPcWrite: assert property (@(posedge clk) we |-> wa != isaPkg::pcReg);

endmodule

/* source/instrDecoder.sv */
`include "core_cfg.svh"

module instrDecoder (
  input  isaPkg::instrWordT       instr,
  output pipePkg::ctrlT           ctrl,
  output isaPkg::regAddrT         rn,
  output isaPkg::regAddrT         rm,
  output isaPkg::regAddrT         rd,
  output logic [`DATA_WIDTH-1:0]  extImm
);

  logic                     condOk;
  logic                     isMem;
  logic                     dpOk;
  logic                     memOk;
  logic [4:0]               rotAmt;
  logic [`DATA_WIDTH-1:0]   imm8Ext;
  logic [2*`DATA_WIDTH-1:0] imm8Rot;

  assign condOk = instr.dp.cond == isaPkg::condAlways;
  assign isMem  = instr.dp.op == isaPkg::opMemory;

  // Register form is accepted only without a shift
  assign dpOk = (instr.dp.op == isaPkg::opDataProc) &&
                (instr.dp.immFlag || instr.dp.operand2[11:4] == 8'd0) &&
                (instr.dp.opcode inside {isaPkg::ANDop, isaPkg::SUBop, isaPkg::ADDop,
                                         isaPkg::ORRop, isaPkg::MOVop});

  // Word access, immediate offset, no base update
  assign memOk = isMem && !instr.mem.immFlag && instr.mem.preIndex &&
                 !instr.mem.byteFlag && !instr.mem.writeBack;

  // Register fields sit at the same bits in both views
  assign rn = instr.dp.rn;
  assign rd = instr.dp.rd;
  assign rm = isMem ? instr.mem.rd : instr.dp.operand2[3:0];  // Store data comes in on port 2

  // imm8 rotated right by twice the rotate field
  assign rotAmt  = {instr.dp.operand2[11:8], 1'b0};
  assign imm8Ext = {{(`DATA_WIDTH-8){1'b0}}, instr.dp.operand2[7:0]};
  assign imm8Rot = {imm8Ext, imm8Ext} >> rotAmt;

  assign extImm = isMem ? {{(`DATA_WIDTH-12){1'b0}}, instr.mem.imm12}
                        : imm8Rot[`DATA_WIDTH-1:0];

  always_comb begin
    ctrl = '0;  // No-op unless proven otherwise
    if (condOk && rd != isaPkg::pcReg) begin
      if (dpOk) begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = instr.dp.immFlag;
        ctrl.aluOp     = isaPkg::aluOpT'(instr.dp.opcode);
      end else if (memOk) begin
        ctrl.aluSrcImm = 1'b1;  // Address is base +/- imm12
        ctrl.aluOp     = instr.mem.up ? isaPkg::ADDop : isaPkg::SUBop;
        if (instr.mem.load) begin
          ctrl.regWrite = 1'b1;
          ctrl.memToReg = 1'b1;
        end else begin
          ctrl.memWrite = 1'b1;
        end
      end
    end
  end

endmodule

/* source/pipePkg.sv */
`include "core_cfg.svh"

package pipePkg;

  // Control bits produced in decode and carried down the pipe
  typedef struct packed {
    logic          regWrite;
    logic          memWrite;
    logic          memToReg;   // Also marks a load
    logic          aluSrcImm;  // Source B from the immediate
    isaPkg::aluOpT aluOp;
  } ctrlT;

  // Decode to execute
  typedef struct packed {
    ctrlT                   ctrl;
    isaPkg::regAddrT        rn;
    isaPkg::regAddrT        rm;
    isaPkg::regAddrT        rd;
    logic [`DATA_WIDTH-1:0] rd1;
    logic [`DATA_WIDTH-1:0] rd2;
    logic [`DATA_WIDTH-1:0] extImm;
  } decExT;

  // Execute to memory
  typedef struct packed {
    ctrlT                   ctrl;
    isaPkg::regAddrT        rd;
    logic [`DATA_WIDTH-1:0] aluOut;     // Result or memory address
    logic [`DATA_WIDTH-1:0] writeData;  // Store data after forwarding
  } exMemT;

  // Memory to writeback, only what writeback still needs
  typedef struct packed {
    logic                   regWrite;
    logic                   memToReg;
    isaPkg::regAddrT        rd;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic [`DATA_WIDTH-1:0] readData;
  } memWbT;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwdNone = 2'b00,  // Value read in decode
    fwdWb   = 2'b01,  // Writeback result
    fwdMem  = 2'b10   // ALU output held in memory stage
  } fwdSelT;

  // Data memory request from the memory stage
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic                   write;
  } dataBusT;

  // Register file write as seen from outside
  typedef struct packed {
    logic                   valid;
    isaPkg::regAddrT        regAddr;
    logic [`DATA_WIDTH-1:0] data;
  } wbPortT;

endpackage

/* source/isaPkg.sv */
`include "core_cfg.svh"

package isaPkg;

  typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

  // Opcode values follow the ARM data-processing encoding
  typedef enum logic [3:0] {
    ANDop = 4'b0000,
    SUBop = 4'b0010,
    ADDop = 4'b0100,
    ORRop = 4'b1100,
    MOVop = 4'b1101
  } aluOpT;

  localparam logic [3:0] condAlways = 4'b1110;  // Only this condition executes
  localparam logic [1:0] opDataProc = 2'b00;
  localparam logic [1:0] opMemory   = 2'b01;
  localparam regAddrT    pcReg      = regAddrT'(`REG_COUNT - 1);  // r15

  // Data-processing view of an instruction word
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immFlag;   // Operand2 is a rotated imm8
    logic [3:0]  opcode;
    logic        setFlags;  // Ignored, no flags kept
    regAddrT     rn;
    regAddrT     rd;
    logic [11:0] operand2;  // rot:imm8 or shift:rm
  } dpFieldsT;

  // Load/store view of the same word
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immFlag;   // Set means register offset
    logic        preIndex;
    logic        up;        // Add offset when set, subtract when clear
    logic        byteFlag;
    logic        writeBack;
    logic        load;
    regAddrT     rn;        // Base register
    regAddrT     rd;        // Load target or store source
    logic [11:0] imm12;
  } memFieldsT;

  // One word, decoded either way depending on op
  typedef union packed {
    dpFieldsT  dp;
    memFieldsT mem;
  } instrWordT;

endpackage

/* source/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath word size in bits
`define DATA_WIDTH 32

// Architectural registers r0..r15
`define REG_COUNT 16

// Bits needed to name one register
`define REG_ADDR_WIDTH 4

// Fetch restarts here after reset
`define RESET_PC 0

// Byte distance between consecutive instructions
`define PC_STEP 4

`endif
